//--- common/ext_dev_consts.svh
/*
 * External device sizes
 * Memory geometry, latency, buffer depth and copy register offsets
 */
`ifndef EXT_DEV_CONSTS_SVH
`define EXT_DEV_CONSTS_SVH

`define SLOW_MEM_WORDS   128
`define SLOW_MEM_LATENCY 3
`define COPY_FIFO_DEPTH  4

// Register offsets, SIZE counts words
`define MC_REG_SRC    32'h0000_0000
`define MC_REG_DST    32'h0000_0004
`define MC_REG_SIZE   32'h0000_0008
`define MC_REG_START  32'h0000_000C
`define MC_REG_STATUS 32'h0000_0010

`endif

//--- common/ext_dev_pkg.sv
/*
 * External device package
 * Bus, register-bus and FSM types shared by the copy block, arbiter and memory
 */
`default_nettype none

package ext_dev_pkg;

  // Bus request from one master, byte address
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // Bus response, one rvalid per accepted transfer
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // Register bus access
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Read and write engine state
  typedef enum logic [1:0] {
    IDLE,
    RUN
  } copy_state_e;

  // Master that owns the outstanding memory access
  typedef enum logic [1:0] {
    OWN_EXT,
    OWN_WR,
    OWN_RD
  } bus_owner_e;

endpackage

`default_nettype wire

//--- ext_dev.f
+incdir+common
common/ext_dev_pkg.sv
memcopy/memcopy_regs.sv
memcopy/memcopy_reader.sv
memcopy/memcopy_fifo.sv
memcopy/memcopy_writer.sv
memcopy/memcopy_periph.sv
src/obi_arbiter.sv
src/slow_memory.sv
src/ext_dev_top.sv
testbench/tb_ext_dev.sv

//--- memcopy/memcopy_fifo.sv
/*
 * Memcopy word buffer
 * Circular FIFO between the read and write engines
 */
`timescale 1ns/1ps
`default_nettype none

`include "ext_dev_consts.svh"

module memcopy_fifo #(
  parameter int DEPTH = `COPY_FIFO_DEPTH
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  input  wire logic                       push_i,
  input  wire logic [31:0]                push_data_i,
  input  wire logic                       pop_i,
  output logic [31:0]                     pop_data_o,
  output logic                            empty_o,
  output logic [$clog2(DEPTH+1)-1:0]      count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [31:0]      mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;

  assign full       = (count_q == CNT_W'(DEPTH));
  assign empty_o    = (count_q == '0);
  assign count_o    = count_q;
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push_i && !pop_i) count_q <= count_q + 1'b1;
      else if (pop_i && !push_i) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_data_i;
  end

  // Reader credit scheme keeps a slot for every returning word
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full)
    else $error("push into full buffer");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
    else $error("pop from empty buffer");

endmodule

`default_nettype wire

//--- memcopy/memcopy_periph.sv
/*
 * Memcopy peripheral
 * Registers, read engine, word buffer and write engine
 */
`timescale 1ns/1ps
`default_nettype none

module memcopy_periph (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire ext_dev_pkg::reg_req_t  reg_req_i,
  output ext_dev_pkg::reg_rsp_t       reg_rsp_o,
  output ext_dev_pkg::obi_req_t       rd_req_o,
  input  wire ext_dev_pkg::obi_resp_t rd_rsp_i,
  output ext_dev_pkg::obi_req_t       wr_req_o,
  input  wire ext_dev_pkg::obi_resp_t wr_rsp_i,
  output logic                        memcopy_intr_o
);

  logic [31:0] src;
  logic [31:0] dst;
  logic [31:0] size;
  logic        start;
  logic        busy;
  logic        push;
  logic [31:0] push_data;
  logic        pop;
  logic [31:0] pop_data;
  logic        empty;
  logic [2:0]  fifo_count;

  memcopy_regs u_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o),
    .busy_i    (busy),
    .src_o     (src),
    .dst_o     (dst),
    .size_o    (size),
    .start_o   (start)
  );

  memcopy_reader u_reader (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start),
    .src_i        (src),
    .size_i       (size),
    .obi_req_o    (rd_req_o),
    .obi_rsp_i    (rd_rsp_i),
    .fifo_count_i (fifo_count),
    .push_o       (push),
    .push_data_o  (push_data)
  );

  memcopy_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .pop_data_o  (pop_data),
    .empty_o     (empty),
    .count_o     (fifo_count)
  );

  memcopy_writer u_writer (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (start),
    .dst_i      (dst),
    .size_i     (size),
    .empty_i    (empty),
    .pop_data_i (pop_data),
    .pop_o      (pop),
    .obi_req_o  (wr_req_o),
    .obi_rsp_i  (wr_rsp_i),
    .busy_o     (busy),
    .intr_o     (memcopy_intr_o)
  );

endmodule

`default_nettype wire

//--- memcopy/memcopy_reader.sv
/*
 * Memcopy read engine
 * Reads the source region and pushes each returned word into the buffer
 */
`timescale 1ns/1ps
`default_nettype none

`include "ext_dev_consts.svh"

module memcopy_reader (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   start_i,
  input  wire logic [31:0]            src_i,
  input  wire logic [31:0]            size_i,
  output ext_dev_pkg::obi_req_t       obi_req_o,
  input  wire ext_dev_pkg::obi_resp_t obi_rsp_i,
  input  wire logic [2:0]             fifo_count_i,
  output logic                        push_o,
  output logic [31:0]                 push_data_o
);

  ext_dev_pkg::copy_state_e state_q;
  logic [31:0] addr_q;
  logic [31:0] size_q;
  logic [31:0] issued_q;
  logic [31:0] done_q;
  logic [31:0] inflight;
  logic        room;
  logic        rd_accept;

  // Reserve a buffer slot for every read still in flight
  assign inflight = issued_q - done_q;
  assign room     = ({29'b0, fifo_count_i} + inflight) < 32'(`COPY_FIFO_DEPTH);

  assign obi_req_o.req   = (state_q == ext_dev_pkg::RUN) && (issued_q != size_q) && room;
  assign obi_req_o.we    = 1'b0;
  assign obi_req_o.addr  = addr_q;
  assign obi_req_o.wdata = '0;

  assign rd_accept   = obi_req_o.req && obi_rsp_i.gnt;
  assign push_o      = obi_rsp_i.rvalid;
  assign push_data_o = obi_rsp_i.rdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ext_dev_pkg::IDLE;
      issued_q <= '0;
      done_q   <= '0;
    end else begin
      case (state_q)
        ext_dev_pkg::IDLE: begin
          if (start_i) begin
            state_q  <= ext_dev_pkg::RUN;
            issued_q <= '0;
            done_q   <= '0;
          end
        end
        ext_dev_pkg::RUN: begin
          if (rd_accept) issued_q <= issued_q + 32'd1;
          if (push_o) done_q <= done_q + 32'd1;
          // Done once the last word is back
          if (push_o && (done_q == size_q - 32'd1)) state_q <= ext_dev_pkg::IDLE;
        end
        default: state_q <= ext_dev_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ext_dev_pkg::IDLE && start_i) begin
      addr_q <= src_i;
      size_q <= size_i;
    end else if (rd_accept) begin
      addr_q <= addr_q + 32'd4;
    end
  end

  // More returned words than size would mean an extra read went out
  a_rd_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_o |-> (state_q == ext_dev_pkg::RUN) && (done_q < size_q))
    else $error("reader got more words than the copy size");

endmodule

`default_nettype wire

//--- memcopy/memcopy_regs.sv
/*
 * Memcopy register front end
 * Holds source, destination and size, forms the start pulse and reports busy
 */
`timescale 1ns/1ps
`default_nettype none

`include "ext_dev_consts.svh"

module memcopy_regs (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire ext_dev_pkg::reg_req_t reg_req_i,
  output ext_dev_pkg::reg_rsp_t      reg_rsp_o,
  input  wire logic                  busy_i,
  output logic [31:0]                src_o,
  output logic [31:0]                dst_o,
  output logic [31:0]                size_o,
  output logic                       start_o
);

  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] size_q;
  logic [31:0] rdata;
  logic        hit;
  logic        wr_en;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  // Full address decode, anything else is an error
  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (reg_req_i.addr)
      `MC_REG_SRC:    rdata = src_q;
      `MC_REG_DST:    rdata = dst_q;
      `MC_REG_SIZE:   rdata = size_q;
      `MC_REG_START:  rdata = '0;
      `MC_REG_STATUS: rdata = {31'b0, busy_i};
      default:        hit   = 1'b0;
    endcase
  end

  assign reg_rsp_o.ready = reg_req_i.valid;
  assign reg_rsp_o.error = reg_req_i.valid && !hit;
  assign reg_rsp_o.rdata = rdata;

  // Start is dropped for an empty copy or while one is running
  assign start_o = wr_en && (reg_req_i.addr == `MC_REG_START) && (size_q != '0) && !busy_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q  <= '0;
      dst_q  <= '0;
      size_q <= '0;
    end else if (wr_en) begin
      if (reg_req_i.addr == `MC_REG_SRC) src_q <= reg_req_i.wdata;
      if (reg_req_i.addr == `MC_REG_DST) dst_q <= reg_req_i.wdata;
      if (reg_req_i.addr == `MC_REG_SIZE) size_q <= reg_req_i.wdata;
    end
  end

  assign src_o  = src_q;
  assign dst_o  = dst_q;
  assign size_o = size_q;

  // Writer must pick up every start on the next edge
  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_o |-> !busy_i ##1 busy_i)
    else $error("start pulse while busy or not followed by busy");

endmodule

`default_nettype wire

//--- memcopy/memcopy_writer.sv
/*
 * Memcopy write engine
 * Drains the buffer into the destination and raises the interrupt when done
 */
`timescale 1ns/1ps
`default_nettype none

module memcopy_writer (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   start_i,
  input  wire logic [31:0]            dst_i,
  input  wire logic [31:0]            size_i,
  input  wire logic                   empty_i,
  input  wire logic [31:0]            pop_data_i,
  output logic                        pop_o,
  output ext_dev_pkg::obi_req_t       obi_req_o,
  input  wire ext_dev_pkg::obi_resp_t obi_rsp_i,
  output logic                        busy_o,
  output logic                        intr_o
);

  ext_dev_pkg::copy_state_e state_q;
  logic [31:0] addr_q;
  logic [31:0] size_q;
  logic [31:0] done_q;
  logic        intr_q;
  logic        last;

  // Write straight from the buffer head, pop once the bus takes it
  assign obi_req_o.req   = (state_q == ext_dev_pkg::RUN) && !empty_i;
  assign obi_req_o.we    = 1'b1;
  assign obi_req_o.addr  = addr_q;
  assign obi_req_o.wdata = pop_data_i;

  assign pop_o  = obi_req_o.req && obi_rsp_i.gnt;
  assign last   = obi_rsp_i.rvalid && (done_q == size_q - 32'd1);
  assign busy_o = (state_q == ext_dev_pkg::RUN);
  assign intr_o = intr_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ext_dev_pkg::IDLE;
      done_q  <= '0;
      intr_q  <= 1'b0;
    end else begin
      intr_q <= 1'b0;
      case (state_q)
        ext_dev_pkg::IDLE: begin
          if (start_i) begin
            state_q <= ext_dev_pkg::RUN;
            done_q  <= '0;
          end
        end
        ext_dev_pkg::RUN: begin
          if (obi_rsp_i.rvalid) done_q <= done_q + 32'd1;
          // Last write completion ends the copy
          if (last) begin
            state_q <= ext_dev_pkg::IDLE;
            intr_q  <= 1'b1;
          end
        end
        default: state_q <= ext_dev_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ext_dev_pkg::IDLE && start_i) begin
      addr_q <= dst_i;
      size_q <= size_i;
    end else if (pop_o) begin
      addr_q <= addr_q + 32'd4;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the external device testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f ext_dev.f --top-module tb_ext_dev \
  -o sim_ext_dev \
  && ./obj_dir/sim_ext_dev | tee /dev/stderr | grep -q "Testbench passed" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- src/ext_dev_top.sv
/*
 * External device subsystem top
 * Copy peripheral and external port share the slow memory through the arbiter
 */
`timescale 1ns/1ps
`default_nettype none

module ext_dev_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire ext_dev_pkg::reg_req_t  reg_req_i,
  output ext_dev_pkg::reg_rsp_t       reg_rsp_o,
  input  wire ext_dev_pkg::obi_req_t  ext_obi_req_i,
  output ext_dev_pkg::obi_resp_t      ext_obi_rsp_o,
  output logic                        memcopy_intr_o
);

  ext_dev_pkg::obi_req_t  rd_req;
  ext_dev_pkg::obi_resp_t rd_rsp;
  ext_dev_pkg::obi_req_t  wr_req;
  ext_dev_pkg::obi_resp_t wr_rsp;
  ext_dev_pkg::obi_req_t  mem_req;
  ext_dev_pkg::obi_resp_t mem_rsp;

  memcopy_periph u_memcopy_periph (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .reg_req_i      (reg_req_i),
    .reg_rsp_o      (reg_rsp_o),
    .rd_req_o       (rd_req),
    .rd_rsp_i       (rd_rsp),
    .wr_req_o       (wr_req),
    .wr_rsp_i       (wr_rsp),
    .memcopy_intr_o (memcopy_intr_o)
  );

  obi_arbiter u_obi_arbiter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ext_req_i (ext_obi_req_i),
    .ext_rsp_o (ext_obi_rsp_o),
    .wr_req_i  (wr_req),
    .wr_rsp_o  (wr_rsp),
    .rd_req_i  (rd_req),
    .rd_rsp_o  (rd_rsp),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp)
  );

  slow_memory u_slow_memory (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .obi_req_i (mem_req),
    .obi_rsp_o (mem_rsp)
  );

endmodule

`default_nettype wire

//--- src/obi_arbiter.sv
/*
 * Bus arbiter
 * Fixed priority external, writer, reader onto one memory port
 */
`timescale 1ns/1ps
`default_nettype none

module obi_arbiter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire ext_dev_pkg::obi_req_t  ext_req_i,
  output ext_dev_pkg::obi_resp_t      ext_rsp_o,
  input  wire ext_dev_pkg::obi_req_t  wr_req_i,
  output ext_dev_pkg::obi_resp_t      wr_rsp_o,
  input  wire ext_dev_pkg::obi_req_t  rd_req_i,
  output ext_dev_pkg::obi_resp_t      rd_rsp_o,
  output ext_dev_pkg::obi_req_t       mem_req_o,
  input  wire ext_dev_pkg::obi_resp_t mem_rsp_i
);

  ext_dev_pkg::bus_owner_e sel;
  ext_dev_pkg::bus_owner_e owner_q;
  logic                    win_gnt;

  // Grant goes to the current winner, response to the recorded owner
  function automatic ext_dev_pkg::obi_resp_t route(
    input ext_dev_pkg::bus_owner_e who,
    input ext_dev_pkg::bus_owner_e cur,
    input ext_dev_pkg::bus_owner_e own,
    input logic                    gnt,
    input ext_dev_pkg::obi_resp_t  rsp
  );
    ext_dev_pkg::obi_resp_t r;
    r.gnt    = gnt && (cur == who);
    r.rvalid = rsp.rvalid && (own == who);
    r.rdata  = (own == who) ? rsp.rdata : '0;
    return r;
  endfunction

  always_comb begin
    sel       = ext_dev_pkg::OWN_EXT;
    mem_req_o = '0;
    if (ext_req_i.req) begin
      mem_req_o = ext_req_i;
    end else if (wr_req_i.req) begin
      sel       = ext_dev_pkg::OWN_WR;
      mem_req_o = wr_req_i;
    end else if (rd_req_i.req) begin
      sel       = ext_dev_pkg::OWN_RD;
      mem_req_o = rd_req_i;
    end
  end

  assign win_gnt   = mem_req_o.req && mem_rsp_i.gnt;
  assign ext_rsp_o = route(ext_dev_pkg::OWN_EXT, sel, owner_q, win_gnt, mem_rsp_i);
  assign wr_rsp_o  = route(ext_dev_pkg::OWN_WR, sel, owner_q, win_gnt, mem_rsp_i);
  assign rd_rsp_o  = route(ext_dev_pkg::OWN_RD, sel, owner_q, win_gnt, mem_rsp_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owner_q <= ext_dev_pkg::OWN_EXT;
    end else if (win_gnt) begin
      owner_q <= sel;
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({ext_rsp_o.gnt, wr_rsp_o.gnt, rd_rsp_o.gnt}))
    else $error("more than one master granted");

endmodule

`default_nettype wire

//--- src/slow_memory.sv
/*
 * Slow word memory
 * One outstanding access, response after a fixed latency
 */
`timescale 1ns/1ps
`default_nettype none

`include "ext_dev_consts.svh"

module slow_memory (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire ext_dev_pkg::obi_req_t obi_req_i,
  output ext_dev_pkg::obi_resp_t     obi_rsp_o
);

  localparam int IDX_W = $clog2(`SLOW_MEM_WORDS);
  localparam int CNT_W = $clog2(`SLOW_MEM_LATENCY + 1);

  logic [31:0]      mem_q [`SLOW_MEM_WORDS];
  logic [31:0]      rdata_q;
  logic [CNT_W-1:0] cnt_q;
  logic             pending_q;
  logic             accept;
  logic [IDX_W-1:0] idx;

  // Upper address bits wrap
  assign idx    = obi_req_i.addr[IDX_W+1:2];
  assign accept = obi_req_i.req && !pending_q;

  assign obi_rsp_o.gnt    = accept;
  assign obi_rsp_o.rvalid = pending_q && (cnt_q == '0);
  assign obi_rsp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      cnt_q     <= '0;
    end else if (accept) begin
      pending_q <= 1'b1;
      cnt_q     <= CNT_W'(`SLOW_MEM_LATENCY - 1);
    end else if (pending_q) begin
      if (cnt_q == '0) pending_q <= 1'b0;
      else cnt_q <= cnt_q - 1'b1;
    end
  end

  // Writes land on acceptance, reads are sampled then and held
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (obi_req_i.we) mem_q[idx] <= obi_req_i.wdata;
      else rdata_q <= mem_q[idx];
    end
  end

  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |-> ##(`SLOW_MEM_LATENCY) (obi_rsp_o.rvalid ##1 !obi_rsp_o.rvalid))
    else $error("response not at fixed latency");

endmodule

`default_nettype wire

//--- testbench/tb_ext_dev.sv
/*
 * Testbench for the external device subsystem
 * Random register, bus and copy traffic checked against a memory and register model
 */
`timescale 1ns/1ps
`default_nettype none

`include "ext_dev_consts.svh"

module tb_ext_dev;

  // Six copies of up to 16 words plus a full memory fill each take about 1000 cycles
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int WORDS          = `SLOW_MEM_WORDS;

  logic                   clk;
  logic                   rst_n;
  ext_dev_pkg::reg_req_t  reg_req;
  ext_dev_pkg::reg_rsp_t  reg_rsp;
  ext_dev_pkg::obi_req_t  ext_req;
  ext_dev_pkg::obi_resp_t ext_rsp;
  logic                   intr;

  logic [31:0] model_mem [WORDS];
  logic [31:0] rng_state;
  int          intr_count;
  int          cycle_count;
  int          check_count;
  int          error_count;
  int          test_count;
  int          test_errors;

  ext_dev_top u_ext_dev_top (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .reg_req_i      (reg_req),
    .reg_rsp_o      (reg_rsp),
    .ext_obi_req_i  (ext_req),
    .ext_obi_rsp_o  (ext_rsp),
    .memcopy_intr_o (intr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
    $display("Testbench failed");
    $finish;
  end

  // Interrupt is a flop output and is sampled at the edge before it updates
  always @(posedge clk) begin
    if (intr) intr_count++;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic start_test();
    test_errors = error_count;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (error_count == test_errors) $display("%s: ok", name);
    else $display("%s: %0d errors", name, error_count - test_errors);
  endtask

  // One register access held for a single rising edge
  task automatic reg_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk);
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    #1;
    rdata = reg_rsp.rdata;
    err   = reg_rsp.error;
    check_word("reg_rsp_o.ready", {31'b0, reg_rsp.ready}, 32'd1);
    @(negedge clk);
    reg_req = '0;
  endtask

  // Mapped offsets only, so no error is expected
  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_rdata;
    logic        err;
    reg_access(1'b1, addr, wdata, unused_rdata, err);
    check_word("reg_rsp_o.error", {31'b0, err}, 32'd0);
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] rdata);
    logic err;
    reg_access(1'b0, addr, '0, rdata, err);
    check_word("reg_rsp_o.error", {31'b0, err}, 32'd0);
  endtask

  // External bus access that waits for grant and then for the response
  task automatic bus_access(input logic we, input int idx, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(negedge clk);
    ext_req.req   = 1'b1;
    ext_req.we    = we;
    ext_req.addr  = 32'(idx) << 2;
    ext_req.wdata = wdata;
    #1;
    while (!ext_rsp.gnt) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ext_req = '0;
    #1;
    while (!ext_rsp.rvalid) begin
      @(negedge clk);
      #1;
    end
    rdata = ext_rsp.rdata;
  endtask

  task automatic bus_write(input int idx, input logic [31:0] wdata);
    logic [31:0] unused_rdata;
    bus_access(1'b1, idx, wdata, unused_rdata);
    model_mem[idx] = wdata;
  endtask

  task automatic bus_read_check(input int idx);
    logic [31:0] rdata;
    bus_access(1'b0, idx, '0, rdata);
    check_word($sformatf("ext_obi_rsp_o.rdata[word %0d]", idx), rdata, model_mem[idx]);
  endtask

  // Copy between two random disjoint regions with optional external reads alongside
  task automatic run_copy(input logic with_traffic);
    int          n;
    int          s;
    int          d;
    int          idx;
    int          intr_before;
    logic [31:0] status;
    n = 1 + int'(rand_next() % 32'd16);
    s = int'(rand_next() % 32'(WORDS + 1 - n));
    d = int'(rand_next() % 32'(WORDS + 1 - n));
    while (d < s + n && s < d + n) d = int'(rand_next() % 32'(WORDS + 1 - n));
    for (int i = 0; i < WORDS; i++) bus_write(i, rand_next());
    reg_write(`MC_REG_SRC, 32'(s) << 2);
    reg_write(`MC_REG_DST, 32'(d) << 2);
    reg_write(`MC_REG_SIZE, 32'(n));
    for (int i = 0; i < n; i++) model_mem[d + i] = model_mem[s + i];
    intr_before = intr_count;
    reg_write(`MC_REG_START, 32'd1);
    reg_read(`MC_REG_STATUS, status);
    check_word("STATUS after start", status, 32'd1);
    if (with_traffic) begin
      for (int k = 0; k < 8; k++) begin
        idx = int'(rand_next() % 32'(WORDS));
        while ((idx >= s && idx < s + n) || (idx >= d && idx < d + n)) begin
          idx = int'(rand_next() % 32'(WORDS));
        end
        bus_read_check(idx);
      end
    end
    while (intr_count == intr_before) @(negedge clk);
    repeat (20) @(negedge clk);
    check_word("memcopy_intr_o pulses", 32'(intr_count - intr_before), 32'd1);
    reg_read(`MC_REG_STATUS, status);
    check_word("STATUS after copy", status, 32'd0);
    for (int i = 0; i < n; i++) bus_read_check(d + i);
  endtask

  initial begin
    logic [31:0] vals [3];
    logic [31:0] rdata;
    logic        err;
    int          intr_before;
    rng_state   = 32'd33;
    intr_count  = 0;
    check_count = 0;
    error_count = 0;
    test_count  = 0;
    rst_n       = 1'b0;
    reg_req     = '0;
    ext_req     = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test();
    for (int k = 0; k < 4; k++) begin
      foreach (vals[j]) vals[j] = rand_next();
      reg_write(`MC_REG_SRC, vals[0]);
      reg_write(`MC_REG_DST, vals[1]);
      reg_write(`MC_REG_SIZE, vals[2]);
      reg_read(`MC_REG_SRC, rdata);
      check_word("SRC", rdata, vals[0]);
      reg_read(`MC_REG_DST, rdata);
      check_word("DST", rdata, vals[1]);
      reg_read(`MC_REG_SIZE, rdata);
      check_word("SIZE", rdata, vals[2]);
    end
    reg_read(`MC_REG_STATUS, rdata);
    check_word("STATUS idle", rdata, 32'd0);
    finish_test("register read-back");

    start_test();
    // Bit 8 set keeps the offset off every mapped register
    reg_access(1'b1, (rand_next() | 32'h100) & ~32'h3, rand_next(), rdata, err);
    check_word("reg_rsp_o.error on unmapped write", {31'b0, err}, 32'd1);
    reg_access(1'b0, (rand_next() | 32'h100) & ~32'h3, '0, rdata, err);
    check_word("reg_rsp_o.error on unmapped read", {31'b0, err}, 32'd1);
    check_word("reg_rsp_o.rdata on unmapped read", rdata, 32'd0);
    reg_read(`MC_REG_SRC, rdata);
    check_word("SRC after unmapped write", rdata, vals[0]);
    reg_read(`MC_REG_DST, rdata);
    check_word("DST after unmapped write", rdata, vals[1]);
    reg_read(`MC_REG_SIZE, rdata);
    check_word("SIZE after unmapped write", rdata, vals[2]);
    intr_before = intr_count;
    reg_write(`MC_REG_SIZE, 32'd0);
    reg_write(`MC_REG_START, 32'd1);
    repeat (50) @(negedge clk);
    check_word("memcopy_intr_o pulses for SIZE 0", 32'(intr_count - intr_before), 32'd0);
    reg_read(`MC_REG_STATUS, rdata);
    check_word("STATUS after SIZE 0 start", rdata, 32'd0);
    finish_test("unmapped access and empty start");

    start_test();
    begin
      int idx_list [16];
      foreach (idx_list[k]) begin
        idx_list[k] = int'(rand_next() % 32'(WORDS));
        bus_write(idx_list[k], rand_next());
      end
      foreach (idx_list[k]) bus_read_check(idx_list[k]);
    end
    finish_test("external write and read");

    start_test();
    for (int k = 0; k < 4; k++) run_copy(1'b0);
    finish_test("random copies");

    start_test();
    for (int k = 0; k < 2; k++) run_copy(1'b1);
    finish_test("copies with external traffic");

    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
